//--- flist.f
+incdir+rtl
rtl/lv_pkg.sv
rtl/lv_decode.sv
rtl/lv_alu.sv
rtl/lv_regfile.sv
rtl/lv_core.sv
bench/lv_checker.sv
bench/lv_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log=sim.log

verilator --binary --timing --assert --top-module lv_tb \
  -f flist.f -Mdir "$build_dir" -o lv_sim
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$build_dir/lv_sim" > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "TESTS FAILED" "$log"; then
  exit 1
fi
exit 0

//--- bench/lv_tb.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_tb;
  localparam int imem_words   = 64;
  localparam int drain_cycles = 12;

  localparam logic [10:0] add_bits  = 11'b10001011000;
  localparam logic [10:0] sub_bits  = 11'b11001011000;
  localparam logic [10:0] and_bits  = 11'b10001010000;
  localparam logic [10:0] orr_bits  = 11'b10101010000;
  localparam logic [10:0] ldur_bits = 11'b11111000010;
  localparam logic [10:0] stur_bits = 11'b11111000000;

  logic                    CLOCK = 1'b0;
  logic                    reset = 1'b1;
  logic [`LV_XLEN-1:0]     instr_addr;
  logic [`LV_ILEN-1:0]     instr;
  logic [`LV_XLEN-1:0]     mem_addr;
  logic [`LV_XLEN-1:0]     mem_wdata;
  logic [`LV_XLEN-1:0]     mem_rdata;
  logic                    mem_read;
  logic                    mem_write;
  logic                    wb_write;
  logic [`LV_REG_BITS-1:0] wb_reg;
  logic [`LV_XLEN-1:0]     wb_data;
  logic [`LV_ILEN-1:0]     imem [imem_words];
  logic [`LV_XLEN-1:0]     dmem [32];
  logic                    model_start = 1'b0;
  logic                    check_done;
  int                      chk_errors;
  int                      pending;
  int                      other_errors = 0;
  int                      prog_len = 0;
  int                      seed = 72;
  logic                    timed_out = 1'b0;

  lv_core dut (
    .CLOCK(CLOCK), .reset(reset), .instr_addr(instr_addr), .instr(instr),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_rdata(mem_rdata),
    .mem_read(mem_read), .mem_write(mem_write),
    .wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data)
  );

  lv_checker chk (
    .CLOCK(CLOCK), .reset(reset), .start(model_start), .prog(imem),
    .wb_write(wb_write), .wb_reg(wb_reg), .wb_data(wb_data),
    .mem_read(mem_read), .mem_write(mem_write), .mem_addr(mem_addr),
    .mem_wdata(mem_wdata),
    .done(check_done), .errors(chk_errors), .pending(pending)
  );

  always #20 CLOCK = ~CLOCK;                   // 40 ns period

  assign instr = (instr_addr < `LV_XLEN'(imem_words * 4)) ? imem[instr_addr[7:2]] : '0;
  assign mem_rdata = mem_read ? dmem[mem_addr[4:0]] : '0;

  always @(posedge CLOCK) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        dmem[5'(i)] <= `LV_XLEN'(i * 5);       // Word i holds 5*i
      end
    end else if (mem_write) begin
      dmem[mem_addr[4:0]] <= mem_wdata;
    end
  end

  function automatic logic [31:0] enc_r(input logic [10:0] opc, input int rd, input int rn,
                                        input int rm);
    return {opc, 5'(rm), 6'd0, 5'(rn), 5'(rd)};
  endfunction

  function automatic logic [31:0] enc_d(input logic [10:0] opc, input int rt, input int rn,
                                        input int off);
    return {opc, 9'(off), 2'b00, 5'(rn), 5'(rt)};
  endfunction

  function automatic logic [31:0] enc_b(input int off);
    return {6'b000101, 26'(off)};
  endfunction

  function automatic logic [31:0] enc_cbz(input int rt, input int off);
    return {8'b10110100, 19'(off), 5'(rt)};
  endfunction

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  task automatic put(input logic [31:0] word);
    imem[6'(prog_len)] = word;
    prog_len++;
  endtask

  task automatic begin_test();
    @(posedge CLOCK);
    #1 reset = 1'b1;
    for (int i = 0; i < imem_words; i++) begin
      imem[6'(i)] = '0;
    end
    prog_len = 0;
  endtask

  task automatic run_test(input string name);
    int cycles;
    int limit;
    cycles = 0;
    limit  = 8 * prog_len + 50;
    if (!timed_out) begin
      $display("running %s with %0d instructions", name, prog_len);
      @(posedge CLOCK);
      #1 model_start = 1'b1;                   // Checker builds its expectations
      @(posedge CLOCK);
      #1 model_start = 1'b0;
      repeat (3) @(posedge CLOCK);
      #1 reset = 1'b0;
      while (!check_done && cycles < limit) begin
        @(posedge CLOCK);
        cycles++;
      end
      if (!check_done) begin
        $display("timeout in %s after %0d cycles with %0d expected events missing",
                 name, cycles, pending);
        other_errors++;
        timed_out = 1'b1;
      end else begin
        repeat (drain_cycles) @(posedge CLOCK); // Extra events show up here
      end
    end
  endtask

  task automatic test_random();
    int          rd;
    int          prev_rd;
    logic [10:0] ops [4];
    ops     = '{add_bits, sub_bits, and_bits, orr_bits};
    prev_rd = -1;
    begin_test();
    for (int k = 0; k < 40; k++) begin
      rd = rand_below(32);
      while (rd == prev_rd) begin
        rd = rand_below(32);                   // Same rd twice in a row hits WB priority
      end
      put(enc_r(ops[2'(rand_below(4))], rd, rand_below(32), rand_below(32)));
      prev_rd = rd;
    end
    put(enc_b(0));
    run_test("random");
  endtask

  initial begin
    begin_test();
    put(enc_r(add_bits, 10, 1, 2));
    put(enc_r(sub_bits, 11, 7, 3));
    put(enc_r(and_bits, 12, 6, 5));
    put(enc_r(orr_bits, 13, 9, 4));
    put(enc_b(0));
    run_test("alu");

    begin_test();
    put(enc_r(add_bits, 10, 1, 2));
    put(enc_r(add_bits, 11, 10, 3));           // From MEM
    put(enc_r(sub_bits, 12, 11, 10));          // MEM and WB
    put(enc_r(orr_bits, 13, 12, 10));          // Register file bypass
    put(enc_r(and_bits, 14, 13, 12));
    put(enc_r(add_bits, 15, 14, 14));
    put(enc_b(0));
    run_test("forwarding");

    begin_test();
    put(enc_d(ldur_bits, 10, 2, 4));
    put(enc_r(add_bits, 11, 10, 1));           // Load-use stall
    put(enc_d(stur_bits, 11, 3, 8));
    put(enc_d(ldur_bits, 12, 3, 8));
    put(enc_r(sub_bits, 13, 12, 10));
    put(enc_d(stur_bits, 13, 0, -2));
    put(enc_b(0));
    run_test("load_store");

    begin_test();
    put(enc_cbz(5, 3));                        // Not taken
    put(enc_r(add_bits, 10, 1, 1));
    put(enc_r(sub_bits, 20, 20, 20));
    put(enc_cbz(20, 4));
    put(enc_r(add_bits, 11, 1, 2));
    put(enc_r(add_bits, 12, 1, 2));
    put(enc_r(add_bits, 13, 1, 2));
    put(enc_b(4));
    put(enc_r(orr_bits, 14, 1, 2));
    put(enc_d(stur_bits, 1, 2, 0));
    put(enc_r(sub_bits, 16, 1, 2));
    put(enc_r(add_bits, 15, 10, 20));
    put(enc_b(0));
    run_test("branches");

    begin_test();
    put(enc_r(add_bits, 31, 1, 2));
    put(enc_r(add_bits, 10, 31, 3));
    put(32'hdead_beef);
    put(enc_r(orr_bits, 31, 5, 6));
    put(enc_d(stur_bits, 31, 1, 0));
    put(32'hffff_ffff);
    put(enc_r(add_bits, 11, 31, 31));
    put(enc_b(0));
    run_test("zero_reg");

    test_random();

    $display("errors: %0d (compare %0d, other %0d)", chk_errors + other_errors, chk_errors,
             other_errors);
    if (chk_errors == 0 && other_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/lv_checker.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_checker (
  input  logic                    CLOCK,
  input  logic                    reset,
  input  logic                    start,
  input  logic [`LV_ILEN-1:0]     prog [64],
  input  logic                    wb_write,
  input  logic [`LV_REG_BITS-1:0] wb_reg,
  input  logic [`LV_XLEN-1:0]     wb_data,
  input  logic                    mem_read,
  input  logic                    mem_write,
  input  logic [`LV_XLEN-1:0]     mem_addr,
  input  logic [`LV_XLEN-1:0]     mem_wdata,
  output logic                    done,
  output int                      errors,
  output int                      pending
);
  localparam int max_steps = 400;

  // LEGv8 major opcodes, bits 31:21
  localparam logic [10:0] add_bits  = 11'b10001011000;
  localparam logic [10:0] sub_bits  = 11'b11001011000;
  localparam logic [10:0] and_bits  = 11'b10001010000;
  localparam logic [10:0] orr_bits  = 11'b10101010000;
  localparam logic [10:0] ldur_bits = 11'b11111000010;
  localparam logic [10:0] stur_bits = 11'b11111000000;

  logic [`LV_REG_BITS-1:0] exp_reg [$];
  logic [`LV_XLEN-1:0]     exp_data [$];
  logic [`LV_XLEN-1:0]     exp_addr [$];
  logic [`LV_XLEN-1:0]     exp_wdata [$];
  logic [`LV_XLEN-1:0]     exp_laddr [$];
  int                      err_count = 0;
  int                      left_count = 0;
  logic                    all_seen = 1'b0;

  assign errors  = err_count;
  assign pending = left_count;
  assign done    = all_seen;

  // Field sits in the low bits
  function automatic logic [63:0] sext(input logic [31:0] field, input int bits);
    logic [63:0] v;
    v = {32'b0, field} << (64 - bits);
    return $signed(v) >>> (64 - bits);
  endfunction

  // Executes the program image and queues the expected events
  function automatic void run_model();
    logic [63:0] regs [32];
    logic [63:0] mem [32];
    logic [63:0] pc;
    logic [63:0] addr;
    logic [63:0] off;
    logic [63:0] res;
    logic [31:0] ins;
    logic [4:0]  rd;
    logic [4:0]  rn;
    logic [4:0]  rm;
    logic        wr;
    int          steps;
    exp_reg.delete();
    exp_data.delete();
    exp_addr.delete();
    exp_wdata.delete();
    exp_laddr.delete();
    for (int i = 0; i < 32; i++) begin
      regs[5'(i)] = 64'(i);
      mem[5'(i)]  = 64'(i * 5);
    end
    regs[31] = '0;
    pc       = '0;
    steps    = 0;
    while (steps < max_steps && pc < 64'd256) begin
      ins = prog[pc[7:2]];
      rd  = ins[4:0];
      rn  = ins[9:5];
      rm  = ins[20:16];
      steps++;
      if (ins[31:26] == 6'b000101) begin
        off = sext({6'b0, ins[25:0]}, 26);
        if (off == '0) begin
          break;                               // Branch to itself ends the program
        end
        pc = pc + (off << 2);
      end else if (ins[31:24] == 8'b10110100) begin
        if (regs[rd] == '0) begin
          pc = pc + (sext({13'b0, ins[23:5]}, 19) << 2);
        end else begin
          pc = pc + 64'd4;
        end
      end else begin
        addr = regs[rn] + sext({23'b0, ins[20:12]}, 9);
        wr   = 1'b1;
        res  = '0;
        case (ins[31:21])
          add_bits:  res = regs[rn] + regs[rm];
          sub_bits:  res = regs[rn] - regs[rm];
          and_bits:  res = regs[rn] & regs[rm];
          orr_bits:  res = regs[rn] | regs[rm];
          ldur_bits: begin
            res = mem[addr[4:0]];              // 32 words, address modulo 32
            exp_laddr.push_back(addr);
          end
          stur_bits: begin
            wr             = 1'b0;
            mem[addr[4:0]] = regs[rd];
            exp_addr.push_back(addr);
            exp_wdata.push_back(regs[rd]);
          end
          default:   wr = 1'b0;                // Unknown encoding is a no-op
        endcase
        if (wr && rd != 5'd31) begin
          regs[rd] = res;
          exp_reg.push_back(rd);
          exp_data.push_back(res);
        end
        pc = pc + 64'd4;
      end
    end
    if (steps >= max_steps || pc >= 64'd256) begin
      $display("reference model ran off the end of the program");
      err_count++;
    end
  endfunction

  // Outputs are stable at the falling edge
  always @(negedge CLOCK) begin : compare_events
    logic [`LV_REG_BITS-1:0] er;
    logic [`LV_XLEN-1:0]     ed;
    if (start) begin
      run_model();
    end else if (!reset) begin
      if (wb_write && wb_reg != 5'd31) begin   // XZR writes are dropped
        if (exp_reg.size() == 0) begin
          $display("unexpected register write to X%0d with %h", wb_reg, wb_data);
          err_count++;
        end else begin
          er = exp_reg.pop_front();
          ed = exp_data.pop_front();
          if (wb_reg !== er) begin
            $display("mismatch wb_reg: expected %h, got %h", er, wb_reg);
            err_count++;
          end
          if (wb_data !== ed) begin
            $display("mismatch wb_data: expected %h, got %h", ed, wb_data);
            err_count++;
          end
        end
      end
      if (mem_read) begin
        if (exp_laddr.size() == 0) begin
          $display("unexpected load from %h", mem_addr);
          err_count++;
        end else begin
          ed = exp_laddr.pop_front();
          if (mem_addr !== ed) begin
            $display("mismatch mem_addr: expected %h, got %h", ed, mem_addr);
            err_count++;
          end
        end
      end
      if (mem_write) begin
        if (exp_addr.size() == 0) begin
          $display("unexpected store to %h with %h", mem_addr, mem_wdata);
          err_count++;
        end else begin
          ed = exp_addr.pop_front();
          if (mem_addr !== ed) begin
            $display("mismatch mem_addr: expected %h, got %h", ed, mem_addr);
            err_count++;
          end
          ed = exp_wdata.pop_front();
          if (mem_wdata !== ed) begin
            $display("mismatch mem_wdata: expected %h, got %h", ed, mem_wdata);
            err_count++;
          end
        end
      end
    end
    left_count = exp_reg.size() + exp_addr.size() + exp_laddr.size();
    all_seen   = (left_count == 0);
  end

endmodule

//--- rtl/lv_core.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_core (
  input  logic                    CLOCK,
  input  logic                    reset,
  output logic [`LV_XLEN-1:0]     instr_addr,
  input  logic [`LV_ILEN-1:0]     instr,
  output logic [`LV_XLEN-1:0]     mem_addr,
  output logic [`LV_XLEN-1:0]     mem_wdata,
  input  logic [`LV_XLEN-1:0]     mem_rdata,
  output logic                    mem_read,
  output logic                    mem_write,
  output logic                    wb_write,
  output logic [`LV_REG_BITS-1:0] wb_reg,
  output logic [`LV_XLEN-1:0]     wb_data
);
  import lv_pkg::*;

  localparam logic [`LV_REG_BITS-1:0] zero_reg = `LV_ZERO_REG;

  logic [`LV_XLEN-1:0]     pc;
  logic [`LV_XLEN-1:0]     ifid_pc;
  logic [`LV_ILEN-1:0]     ifid_instr;
  logic                    ifid_valid;
  ctrl_t                   dec_ctrl;
  logic [`LV_REG_BITS-1:0] id_rn;
  logic [`LV_REG_BITS-1:0] id_rb;
  logic [`LV_XLEN-1:0]     id_imm;
  logic [`LV_XLEN-1:0]     rf_a;
  logic [`LV_XLEN-1:0]     rf_b;
  logic                    stall;
  logic                    take_branch;
  idex_t                   idex;
  idex_t                   idex_next;
  exmem_t                  exmem;
  exmem_t                  exmem_next;
  memwb_t                  memwb;
  memwb_t                  memwb_next;
  fwd_sel_e                fwd_a;
  fwd_sel_e                fwd_b;
  logic [`LV_XLEN-1:0]     ex_a;
  logic [`LV_XLEN-1:0]     ex_b;
  logic [`LV_XLEN-1:0]     alu_result;
  logic                    alu_zero;

  // WB is checked first, then MEM
  function automatic fwd_sel_e fwd_pick(input logic [`LV_REG_BITS-1:0] src,
                                        input memwb_t wb, input exmem_t mem);
    fwd_sel_e sel;
    sel = fwd_rf;
    if (wb.reg_write && wb.rd != zero_reg && wb.rd == src) begin
      sel = fwd_wb;
    end else if (mem.ctrl.reg_write && mem.rd != zero_reg && mem.rd == src) begin
      sel = fwd_mem;
    end
    return sel;
  endfunction

  function automatic logic [`LV_XLEN-1:0] fwd_mux(input fwd_sel_e sel,
      input logic [`LV_XLEN-1:0] rf_val, input logic [`LV_XLEN-1:0] wb_val,
      input logic [`LV_XLEN-1:0] mem_val);
    case (sel)
      fwd_wb:  return wb_val;
      fwd_mem: return mem_val;
      default: return rf_val;
    endcase
  endfunction

  assign instr_addr = pc;

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      pc <= '0;
    end else if (take_branch) begin
      pc <= exmem.target;
    end else if (!stall) begin
      pc <= pc + `LV_XLEN'(4);
    end
  end

  always_ff @(posedge CLOCK) begin
    if (!stall) begin
      ifid_pc    <= pc;
      ifid_instr <= instr;
    end
    if (reset || take_branch) begin
      ifid_valid <= 1'b0;
    end else if (!stall) begin
      ifid_valid <= 1'b1;
    end
  end

  lv_decode u_decode (
    .instr  (ifid_instr),
    .ctrl   (dec_ctrl),
    .read_b (id_rb),
    .imm    (id_imm)
  );

  assign id_rn = ifid_instr[`LV_RN_HI:`LV_RN_LO];

  lv_regfile u_regfile (
    .CLOCK      (CLOCK),
    .reset      (reset),
    .read_a     (id_rn),
    .read_b     (id_rb),
    .data_a     (rf_a),
    .data_b     (rf_b),
    .write_en   (wb_write),
    .write_reg  (wb_reg),
    .write_data (wb_data)
  );

  // Load-use hazard
  assign stall = ifid_valid && idex.ctrl.mem_read &&
                 (idex.rd == id_rn || idex.rd == id_rb);

  always_comb begin
    idex_next.ctrl   = dec_ctrl;
    idex_next.pc     = ifid_pc;
    idex_next.op_a   = rf_a;
    idex_next.op_b   = rf_b;
    idex_next.imm    = id_imm;
    idex_next.opcode = opcode_e'(ifid_instr[`LV_OPC_HI:`LV_OPC_LO]);
    idex_next.rd     = ifid_instr[`LV_RD_HI:`LV_RD_LO];
    idex_next.rn     = id_rn;
    idex_next.rb     = id_rb;
    idex_next.valid  = ifid_valid && !stall;
    if (!idex_next.valid) begin
      idex_next.ctrl = '0;                     // Bubble
    end
  end

  always_ff @(posedge CLOCK) begin
    idex <= idex_next;
    if (reset || take_branch) begin
      idex.ctrl  <= '0;
      idex.valid <= 1'b0;
    end
  end

  assign fwd_a = fwd_pick(idex.rn, memwb, exmem);
  assign fwd_b = fwd_pick(idex.rb, memwb, exmem);
  assign ex_a  = fwd_mux(fwd_a, idex.op_a, wb_data, exmem.result);
  assign ex_b  = fwd_mux(fwd_b, idex.op_b, wb_data, exmem.result);

  lv_alu u_alu (
    .operand_a (ex_a),
    .operand_b (ex_b),
    .imm       (idex.imm),
    .alu_src   (idex.ctrl.alu_src),
    .alu_op    (idex.ctrl.alu_op),
    .opcode    (idex.opcode),
    .result    (alu_result),
    .zero      (alu_zero)
  );

  always_comb begin
    exmem_next.ctrl       = idex.ctrl;
    exmem_next.target     = idex.pc + (idex.imm << 2);   // Word offset
    exmem_next.result     = alu_result;
    exmem_next.zero       = alu_zero;
    exmem_next.store_data = ex_b;
    exmem_next.rd         = idex.rd;
    exmem_next.valid      = idex.valid;
  end

  always_ff @(posedge CLOCK) begin
    exmem <= exmem_next;
    if (reset || take_branch) begin
      exmem.ctrl  <= '0;
      exmem.valid <= 1'b0;
    end
  end

  // Resolved in MEM, flushes three younger slots
  assign take_branch = exmem.valid &&
                       (exmem.ctrl.uncon_branch || (exmem.ctrl.zero_branch && exmem.zero));

  assign mem_addr  = exmem.result;
  assign mem_wdata = exmem.store_data;
  assign mem_read  = exmem.ctrl.mem_read;
  assign mem_write = exmem.ctrl.mem_write;

  always_comb begin
    memwb_next.reg_write  = exmem.ctrl.reg_write;
    memwb_next.mem_to_reg = exmem.ctrl.mem_to_reg;
    memwb_next.result     = exmem.result;
    memwb_next.load_data  = mem_rdata;
    memwb_next.rd         = exmem.rd;
  end

  always_ff @(posedge CLOCK) begin
    memwb <= memwb_next;
    if (reset) begin
      memwb.reg_write  <= 1'b0;
      memwb.mem_to_reg <= 1'b0;
    end
  end

  assign wb_write = memwb.reg_write;
  assign wb_reg   = memwb.rd;
  assign wb_data  = memwb.mem_to_reg ? memwb.load_data : memwb.result;

  a_mem_excl: assert property (@(posedge CLOCK) disable iff (reset)
    !(mem_read && mem_write))
    else $error("load and store issued in the same cycle");

  // Branch targets must keep word alignment
  a_pc_align: assert property (@(posedge CLOCK) disable iff (reset)
    instr_addr[1:0] == 2'b00)
    else $error("instr_addr not word aligned");

endmodule

//--- rtl/lv_regfile.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_regfile (
  input  logic                    CLOCK,
  input  logic                    reset,
  input  logic [`LV_REG_BITS-1:0] read_a,
  input  logic [`LV_REG_BITS-1:0] read_b,
  output logic [`LV_XLEN-1:0]     data_a,
  output logic [`LV_XLEN-1:0]     data_b,
  input  logic                    write_en,
  input  logic [`LV_REG_BITS-1:0] write_reg,
  input  logic [`LV_XLEN-1:0]     write_data
);
  localparam logic [`LV_REG_BITS-1:0] zero_reg = `LV_ZERO_REG;

  logic [`LV_XLEN-1:0] regs [`LV_NUM_REGS];
  logic                wr_ok;

  assign wr_ok = write_en && (write_reg != zero_reg);   // XZR drops writes

  always_ff @(posedge CLOCK) begin
    if (reset) begin
      for (int i = 0; i < `LV_NUM_REGS; i++) begin
        regs[i] <= `LV_XLEN'(i);               // Xi starts at i
      end
      regs[zero_reg] <= '0;
    end else if (wr_ok) begin
      regs[write_reg] <= write_data;
    end
  end

  // Same-cycle bypass of the WB write
  assign data_a = (wr_ok && write_reg == read_a) ? write_data : regs[read_a];
  assign data_b = (wr_ok && write_reg == read_b) ? write_data : regs[read_b];

  a_zero_reg: assert property (@(posedge CLOCK) disable iff (reset)
    regs[zero_reg] == '0)
    else $error("register 31 holds a nonzero value");

endmodule

//--- rtl/lv_alu.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_alu (
  input  logic [`LV_XLEN-1:0] operand_a,
  input  logic [`LV_XLEN-1:0] operand_b,
  input  logic [`LV_XLEN-1:0] imm,
  input  logic                alu_src,
  input  lv_pkg::alu_op_e     alu_op,
  input  lv_pkg::opcode_e     opcode,
  output logic [`LV_XLEN-1:0] result,
  output logic                zero
);
  import lv_pkg::*;

  alu_op_e             op;
  logic [`LV_XLEN-1:0] in_b;

  // R-type picks its operation from the opcode
  always_comb begin
    case (opcode)
      op_add:  op = alu_add;
      op_sub:  op = alu_sub;
      op_and:  op = alu_and;
      op_orr:  op = alu_or;
      default: op = alu_op;
    endcase
  end

  assign in_b = alu_src ? imm : operand_b;

  always_comb begin
    case (op)
      alu_and:    result = operand_a & in_b;
      alu_or:     result = operand_a | in_b;
      alu_add:    result = operand_a + in_b;
      alu_sub:    result = operand_a - in_b;
      alu_pass_b: result = in_b;
      default:    result = '0;
    endcase
  end

  assign zero = (result == '0);                // CBZ condition

endmodule

//--- rtl/lv_decode.sv
`timescale 1ns/1ps
`include "lv_defines.svh"

module lv_decode (
  input  logic [`LV_ILEN-1:0]     instr,
  output lv_pkg::ctrl_t           ctrl,
  output logic [`LV_REG_BITS-1:0] read_b,
  output logic [`LV_XLEN-1:0]     imm
);
  import lv_pkg::*;

  logic [`LV_OPC_HI:`LV_OPC_LO] opc_bits;
  opcode_e                      opc;

  assign opc_bits = instr[`LV_OPC_HI:`LV_OPC_LO];

  // Branches are matched on their prefix only
  always_comb begin
    casez (opc_bits)
      11'b000101?????: opc = op_b;
      11'b10110100???: opc = op_cbz;
      op_add, op_sub, op_and, op_orr, op_ldur, op_stur: begin
        opc = opcode_e'(opc_bits);
      end
      default:         opc = op_unknown;
    endcase
  end

  always_comb begin
    ctrl = '0;                                 // Unknown stays a no-op
    case (opc)
      op_add, op_sub, op_and, op_orr: begin
        ctrl.reg_write = 1'b1;
        ctrl.alu_op    = alu_add;              // ALU refines from opcode
      end
      op_ldur: begin
        ctrl.alu_src    = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.reg_write  = 1'b1;
        ctrl.mem_to_reg = 1'b1;
        ctrl.alu_op     = alu_add;
      end
      op_stur: begin
        ctrl.alu_src   = 1'b1;
        ctrl.mem_write = 1'b1;
        ctrl.alu_op    = alu_add;
      end
      op_cbz: begin
        ctrl.zero_branch = 1'b1;
        ctrl.alu_op      = alu_pass_b;         // Zero flag tests Rt
      end
      op_b: begin
        ctrl.uncon_branch = 1'b1;
        ctrl.alu_op       = alu_pass_b;
      end
      default: ;
    endcase
  end

  // STUR and CBZ read Rt on the second port
  assign read_b = (opc == op_stur || opc == op_cbz) ? instr[`LV_RD_HI:`LV_RD_LO]
                                                    : instr[`LV_RM_HI:`LV_RM_LO];

  always_comb begin
    case (opc)
      op_b: begin
        imm = {{(`LV_XLEN-`LV_BIMM_HI+`LV_BIMM_LO-1){instr[`LV_BIMM_HI]}},
               instr[`LV_BIMM_HI:`LV_BIMM_LO]};
      end
      op_cbz: begin
        imm = {{(`LV_XLEN-`LV_CBIMM_HI+`LV_CBIMM_LO-1){instr[`LV_CBIMM_HI]}},
               instr[`LV_CBIMM_HI:`LV_CBIMM_LO]};
      end
      default: begin                           // D-type, unused by R-type
        imm = {{(`LV_XLEN-`LV_DIMM_HI+`LV_DIMM_LO-1){instr[`LV_DIMM_HI]}},
               instr[`LV_DIMM_HI:`LV_DIMM_LO]};
      end
    endcase
  end

endmodule

//--- rtl/lv_pkg.sv
`include "lv_defines.svh"

package lv_pkg;

  // Major opcodes, bits 31:21 of the instruction
  typedef enum logic [10:0] {
    op_unknown = 11'b00000000000,
    op_b       = 11'b00010100000,  // Only the 6-bit prefix is decoded
    op_cbz     = 11'b10110100000,  // Only the 8-bit prefix is decoded
    op_add     = 11'b10001011000,
    op_sub     = 11'b11001011000,
    op_and     = 11'b10001010000,
    op_orr     = 11'b10101010000,
    op_ldur    = 11'b11111000010,
    op_stur    = 11'b11111000000
  } opcode_e;

  typedef enum logic [3:0] {
    alu_and    = 4'b0000,
    alu_or     = 4'b0001,
    alu_add    = 4'b0010,
    alu_sub    = 4'b0110,
    alu_pass_b = 4'b0111          // Branch operand straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    fwd_rf  = 2'b00,
    fwd_wb  = 2'b01,
    fwd_mem = 2'b10
  } fwd_sel_e;

  typedef struct packed {
    logic    alu_src;             // Immediate as operand B
    logic    zero_branch;
    logic    uncon_branch;
    logic    mem_read;
    logic    mem_write;
    logic    reg_write;
    logic    mem_to_reg;
    alu_op_e alu_op;
  } ctrl_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    logic [`LV_XLEN-1:0]     pc;
    logic [`LV_XLEN-1:0]     op_a;
    logic [`LV_XLEN-1:0]     op_b;
    logic [`LV_XLEN-1:0]     imm;
    opcode_e                 opcode;
    logic [`LV_REG_BITS-1:0] rd;
    logic [`LV_REG_BITS-1:0] rn;
    logic [`LV_REG_BITS-1:0] rb;  // Rm, or Rt for STUR and CBZ
    logic                    valid;
  } idex_t;

  typedef struct packed {
    ctrl_t                   ctrl;
    logic [`LV_XLEN-1:0]     target;
    logic [`LV_XLEN-1:0]     result;
    logic                    zero;
    logic [`LV_XLEN-1:0]     store_data;
    logic [`LV_REG_BITS-1:0] rd;
    logic                    valid;
  } exmem_t;

  typedef struct packed {
    logic                    reg_write;
    logic                    mem_to_reg;
    logic [`LV_XLEN-1:0]     result;
    logic [`LV_XLEN-1:0]     load_data;
    logic [`LV_REG_BITS-1:0] rd;
  } memwb_t;

endpackage

//--- rtl/lv_defines.svh
`ifndef LV_DEFINES_SVH
`define LV_DEFINES_SVH

// Datapath widths
`define LV_XLEN      64
`define LV_ILEN      32
`define LV_REG_BITS  5
`define LV_NUM_REGS  32
`define LV_ZERO_REG  31          // XZR

// Instruction fields
`define LV_OPC_HI    31
`define LV_OPC_LO    21
`define LV_RM_HI     20
`define LV_RM_LO     16
`define LV_RN_HI     9
`define LV_RN_LO     5
`define LV_RD_HI     4           // Also Rt for STUR and CBZ
`define LV_RD_LO     0

// Immediate fields
`define LV_BIMM_HI   25
`define LV_BIMM_LO   0
`define LV_CBIMM_HI  23
`define LV_CBIMM_LO  5
`define LV_DIMM_HI   20          // DT_address of LDUR and STUR
`define LV_DIMM_LO   12

`endif
